// File: Makefile
TOP = cpuTb

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f verilog/*.sv verilog/*.svh tests/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Finished with errors" sim.log || \
	  ! grep -q "Finished with no errors" sim.log; then \
	  echo "Simulation FAILED"; exit 1; \
	else echo "Simulation passed"; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: tests/cpuTb.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpuTb import cpuPkg::*; ();

  localparam int DRIVE_DLY = 2;     // ns after the rising edge
  localparam int MARGIN    = 2000;  // Watchdog cycles on top of the per word budget

  logic    clk, rst;
  apbReq_s apbReq;
  apbRsp_s apbRsp;
  logic    hlt;
  word_t   pc;

  int    errCount    = 0;
  int    loadedWords = 0;           // Sets the watchdog budget
  int    seed        = 61;
  word_t prog[$];                   // Program being assembled
  word_t progMem[`IMEM_DEPTH];      // Mirror of the instruction memory
  word_t modelRegs[`NUM_REGS];      // Reference register file, kept across runs

  tbClock #(.PERIOD(20)) iCLK (.clk(clk));

  cpu DUT (.clk(clk), .rst(rst), .apbReq(apbReq), .apbRsp(apbRsp), .hlt(hlt), .pc(pc));

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic compareWord(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      errCount++;
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic compareBit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errCount++;
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////
  task automatic apbTransfer(input logic wr, input logic [`APB_AW-1:0] addr,
                             input word_t wdata, output word_t rdata, output logic err);
    @(posedge clk);
    #DRIVE_DLY;
    apbReq.psel    = 1'b1;            // Setup phase
    apbReq.penable = 1'b0;
    apbReq.pwrite  = wr;
    apbReq.paddr   = addr;
    apbReq.pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DLY;
    apbReq.penable = 1'b1;            // Access phase
    @(negedge clk);
    while (!apbRsp.pready) @(negedge clk);  // Wait states
    rdata = apbRsp.prdata;
    err   = apbRsp.pslverr;
    @(posedge clk);
    #DRIVE_DLY;
    apbReq = '0;
  endtask

  task automatic apbWrite(input logic [`APB_AW-1:0] addr, input word_t wdata, output logic err);
    word_t unused;
    apbTransfer(1'b1, addr, wdata, unused, err);
  endtask

  task automatic apbRead(input logic [`APB_AW-1:0] addr, output word_t rdata, output logic err);
    apbTransfer(1'b0, addr, '0, rdata, err);
  endtask

  ////////////////////////////////////////////////////////////
  // Assembler, loader and reference model
  ////////////////////////////////////////////////////////////
  function automatic word_t rInstr(input opcode_e op, input int rd, input int rs, input int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  function automatic word_t iInstr(input opcode_e op, input int rd, input logic [7:0] imm);
    return {op, 4'(rd), imm};
  endfunction

  function automatic word_t fillWord(input int addr);
    return word_t'((addr * 32'h0421) ^ 32'hC3A5);  // Every address bit shows
  endfunction

  task automatic loadProgram();
    logic err;
    foreach (prog[i]) begin
      progMem[i] = prog[i];
      apbWrite(12'(`IMEM_BASE + 4 * i), prog[i], err);
      compareBit($sformatf("pslverr imem[%0d] write", i), 1'b0, err);
    end
    loadedWords += prog.size();
  endtask

  // Sequential ISA, no pipeline; forwarding must make the DUT match it
  task automatic predictRun(output word_t finalPc);
    word_t p, nxt, w;
    logic [3:0] rd, rs, rt;
    bit done;
    int steps;
    p = '0;
    nxt = '0;
    done = 0;
    steps = 0;
    while (!done && steps < 4096) begin
      w  = progMem[p[`IMEM_AW-1:0]];  // Fetch address wraps like the core
      rd = w[11:8];
      rs = w[7:4];
      rt = w[3:0];
      nxt = p + 16'd1;
      case (w[15:12])
        4'd0: modelRegs[rd] = modelRegs[rs] + modelRegs[rt];
        4'd1: modelRegs[rd] = modelRegs[rs] - modelRegs[rt];
        4'd2: modelRegs[rd] = modelRegs[rs] & modelRegs[rt];
        4'd3: modelRegs[rd] = modelRegs[rs] ^ modelRegs[rt];
        4'd4: modelRegs[rd] = {8'h00, w[7:0]};
        4'd6: if (modelRegs[rd] == '0) nxt = p + 16'd1 + {{8{w[7]}}, w[7:0]};
        4'd15: done = 1;
        default: ;                  // No-op codes
      endcase
      p = nxt;
      steps++;
    end
    finalPc = nxt;                  // HLT address plus 1
  endtask

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////
  task automatic startCore();
    logic err;
    apbWrite(`CTRL_ADDR, 16'h0001, err);
    compareBit("pslverr start", 1'b0, err);
  endtask

  task automatic checkRegs();
    word_t data;
    logic err;
    for (int i = 0; i < `NUM_REGS; i++) begin
      apbRead(12'(`REG_BASE + 4 * i), data, err);
      compareWord($sformatf("r%0d", i), modelRegs[i], data);
      compareBit($sformatf("pslverr r%0d read", i), 1'b0, err);
    end
  endtask

  task automatic finishRun();
    word_t expPc;
    @(negedge clk);
    while (!hlt) @(negedge clk);    // Watchdog catches a core that never halts
    predictRun(expPc);
    compareWord("pc", expPc, pc);
    checkRegs();
  endtask

  task automatic runProgram();
    startCore();
    finishRun();
  endtask

  task automatic buildBranchProg();
    prog = {};
    prog.push_back(iInstr(LLI, 1, 8'h00));
    prog.push_back(iInstr(LLI, 9, 8'h00));   // Always zero
    prog.push_back(iInstr(BZ, 1, 8'h02));    // Taken, to 5
    prog.push_back(iInstr(LLI, 2, 8'hEE));   // Skipped
    prog.push_back(iInstr(LLI, 3, 8'hEE));   // Skipped
    prog.push_back(iInstr(LLI, 4, 8'h05));   // Loop counter
    prog.push_back(iInstr(LLI, 5, 8'h01));
    prog.push_back(iInstr(LLI, 6, 8'h00));   // Sum
    prog.push_back(rInstr(ADD, 6, 6, 4));    // Loop head at 8
    prog.push_back(rInstr(SUB, 4, 4, 5));
    prog.push_back(iInstr(BZ, 4, 8'h01));    // Exit to 12
    prog.push_back(iInstr(BZ, 9, 8'hFC));    // Back to 8
    prog.push_back(iInstr(LLI, 7, 8'h03));
    prog.push_back(iInstr(BZ, 7, 8'h01));    // Not taken
    prog.push_back(iInstr(LLI, 8, 8'h77));
    prog.push_back(iInstr(HLT, 0, 8'h00));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic checkResetState();
    word_t data;
    logic err;
    apbRead(`CTRL_ADDR, data, err);
    compareWord("status", 16'h0000, data);
    compareBit("pslverr status read", 1'b0, err);
    compareBit("hlt", 1'b0, hlt);
    compareWord("pc", 16'h0000, pc);
    for (int i = 0; i < `IMEM_DEPTH; i++) begin
      progMem[i] = fillWord(i);
      apbWrite(12'(`IMEM_BASE + 4 * i), progMem[i], err);
    end
    for (int i = 0; i < `IMEM_DEPTH; i++) begin
      apbRead(12'(`IMEM_BASE + 4 * i), data, err);
      compareWord($sformatf("imem[%0d]", i), progMem[i], data);
    end
    loadedWords += `IMEM_DEPTH;
  endtask

  task automatic checkAluForwarding();
    prog = {};
    prog.push_back(iInstr(LLI, 1, 8'h5A));
    prog.push_back(iInstr(LLI, 2, 8'h3C));
    prog.push_back(rInstr(ADD, 3, 1, 2));    // Each one needs the last result
    prog.push_back(rInstr(SUB, 4, 3, 1));
    prog.push_back(rInstr(AND, 5, 4, 3));
    prog.push_back(rInstr(XOR, 6, 5, 4));
    prog.push_back(rInstr(ADD, 7, 6, 6));    // Both operands forwarded
    prog.push_back(rInstr(SUB, 8, 2, 7));    // Wraps below zero
    prog.push_back(iInstr(HLT, 0, 8'h00));
    loadProgram();
    runProgram();
  endtask

  task automatic checkBranches();
    buildBranchProg();
    loadProgram();
    runProgram();
  endtask

  task automatic checkHalt();
    word_t data;
    logic err;
    prog = {};
    prog.push_back(iInstr(LLI, 10, 8'h12));
    prog.push_back(iInstr(LLI, 11, 8'h34));
    prog.push_back(iInstr(HLT, 0, 8'h00));
    prog.push_back(iInstr(LLI, 10, 8'hFF)); // Must never execute
    prog.push_back(iInstr(LLI, 12, 8'hFF));
    prog.push_back(rInstr(ADD, 11, 10, 10));
    loadProgram();
    runProgram();
    apbRead(`CTRL_ADDR, data, err);
    compareWord("status", 16'h0001, data);  // Halted, not running
    compareBit("hlt", 1'b1, hlt);
    repeat (10) @(negedge clk);
    compareWord("pc held", 16'h0003, pc);
  endtask

  task automatic checkApbErrors();
    word_t data;
    logic err;
    apbWrite(12'(`REG_BASE + 8), 16'h1234, err);
    compareBit("pslverr register write", 1'b1, err);
    apbWrite(12'h300, 16'h0001, err);
    compareBit("pslverr unmapped write", 1'b1, err);
    buildBranchProg();
    loadProgram();
    startCore();
    apbWrite(12'(`IMEM_BASE + 4 * 5), 16'hFFFF, err);  // Core still looping
    compareBit("pslverr imem write in run", 1'b1, err);
    finishRun();
    apbRead(12'(`IMEM_BASE + 4 * 5), data, err);
    compareWord("imem[5]", progMem[5], data);
    runProgram();                             // Same results again
  endtask

  task automatic checkRandomOperands();
    logic [7:0] a, b;
    repeat (10) begin
      a = 8'($random(seed));
      b = 8'($random(seed));
      prog = {};
      prog.push_back(iInstr(LLI, 1, a));
      prog.push_back(iInstr(LLI, 2, b));
      prog.push_back(rInstr(ADD, 3, 1, 2));
      prog.push_back(rInstr(SUB, 4, 1, 2));
      prog.push_back(rInstr(AND, 5, 3, 4));
      prog.push_back(rInstr(XOR, 6, 4, 5));
      prog.push_back(iInstr(HLT, 0, 8'h00));
      loadProgram();
      runProgram();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sequencer and watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    apbReq = '0;
    rst    = 1'b1;
    foreach (modelRegs[i]) modelRegs[i] = '0;  // Matches the register file reset
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    checkResetState();
    checkAluForwarding();
    checkBranches();
    checkHalt();
    checkApbErrors();
    checkRandomOperands();
    $display("All tests run, %0d errors", errCount);
    if (errCount == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 200 * loadedWords + MARGIN) begin  // Budget grows with each load
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not complete within %0d cycles", cycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: tests/cpu_asserts.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpuAsserts import cpuPkg::*; (
  input logic    clk,
  input logic    rst,
  input apbReq_s apbReq,
  input apbRsp_s apbRsp,
  input logic    hlt,
  input logic    running,
  input logic    start,
  input word_t   pc
);

  // Register read setup, the debug port needs one wait state
  aRegWait: assert property (@(posedge clk) disable iff (rst)
    (apbReq.psel && !apbReq.penable && !apbReq.pwrite &&
     apbReq.paddr >= `REG_BASE && apbReq.paddr < `REG_BASE + 4 * `NUM_REGS)
    |=> !apbRsp.pready ##1 apbRsp.pready)
    else $error("register read did not complete after one wait state");

  aPcFrozen: assert property (@(posedge clk) disable iff (rst)
    (hlt && !start) |=> $stable(pc))   // Halted core holds its pc
    else $error("pc moved while the core is halted");

  aHaltIdle: assert property (@(posedge clk) disable iff (rst)
    !(hlt && running))
    else $error("hlt and running high together");

  aStartPulse: assert property (@(posedge clk) disable iff (rst)
    start |=> !start)                  // Single cycle strobe
    else $error("start held for more than one cycle");

endmodule

bind cpu cpuAsserts uAsserts (
  .clk(clk), .rst(rst), .apbReq(apbReq), .apbRsp(apbRsp), .hlt(hlt),
  .running(running), .start(start), .pc(pc)
);

// File: tests/tbClock.sv
`timescale 1ns/100ps

// Free running testbench clock
module tbClock #(
  parameter int PERIOD = 20  // ns
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

endmodule

// File: verilog/apbLoader.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module apbLoader import cpuPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  apbReq_s             apbReq,
  input  word_t               dbgData,    // Registered register file read
  input  word_t               imemRdata,  // Program read-back
  input  logic                running,
  input  logic                hlt,
  output apbRsp_s             apbRsp,
  output logic                imemWe,
  output logic [`IMEM_AW-1:0] imemAddr,
  output word_t               imemWdata,
  output regIdx_t             dbgAddr,
  output logic                start
);

  logic [`APB_AW-1:0] imemOff, regOff;  // Offsets into each window
  logic access;                         // Access phase of a transfer
  logic imemHit, regHit, ctrlHit;
  logic regRead;                        // Needs the extra wait state
  logic waitDone;                       // Wait state already spent
  logic accErr;

  // Address decode, wraparound makes low addresses miss too
  assign imemOff = apbReq.paddr - `IMEM_BASE;
  assign regOff  = apbReq.paddr - `REG_BASE;
  assign imemHit = int'(imemOff) < `IMEM_DEPTH * 4;
  assign regHit  = int'(regOff) < `NUM_REGS * 4;
  assign ctrlHit = apbReq.paddr == `CTRL_ADDR;

  assign access  = apbReq.psel && apbReq.penable;
  assign regRead = regHit && !apbReq.pwrite;

  // Register window is read only, program is locked during a run
  assign accErr = !(imemHit || regHit || ctrlHit) ||
                  (apbReq.pwrite && regHit) ||
                  (apbReq.pwrite && imemHit && running);

  ////////////////////////////////////////////////////////////
  // Side effects, only on error free accesses
  ////////////////////////////////////////////////////////////
  assign imemAddr  = imemOff[`IMEM_AW+1:2];     // Byte to word
  assign imemWdata = apbReq.pwdata;
  assign imemWe    = access && apbReq.pwrite && imemHit && !running;
  assign dbgAddr   = regOff[REG_AW+1:2];        // Held from setup on
  assign start     = access && apbReq.pwrite && ctrlHit && apbReq.pwdata[0];

  // One wait state so the debug port can register its data
  always_ff @(posedge clk) begin
    if (rst) waitDone <= 1'b0;
    else     waitDone <= access && regRead && !waitDone;
  end

  always_comb begin
    apbRsp.pready  = access && (!regRead || waitDone);
    apbRsp.pslverr = apbRsp.pready && accErr;
    apbRsp.prdata  = '0;
    if (imemHit)      apbRsp.prdata = imemRdata;
    else if (regHit)  apbRsp.prdata = dbgData;
    else if (ctrlHit) apbRsp.prdata = {{(`DATA_W-2){1'b0}}, running, hlt};
  end

endmodule

`default_nettype wire

// File: verilog/cpu.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module cpu import cpuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  apbReq_s apbReq,
  output apbRsp_s apbRsp,
  output logic    hlt,
  output word_t   pc
);

  ////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////
  logic                imemWe;
  logic [`IMEM_AW-1:0] imemAddr;
  word_t               imemWdata, imemRdata;  // Host side of the program store
  logic [`IMEM_AW-1:0] fetchAddr;
  instr_u              fetchInstr;
  regIdx_t             dbgAddr, rsAddr, rtAddr, wbAddr;
  word_t               dbgData, rsData, rtData, wbData;
  logic                wbWe;
  logic                start, running;

  // Host loader, fills the program and reads results
  apbLoader iLOADER (
    .clk(clk), .rst(rst),
    .apbReq(apbReq), .apbRsp(apbRsp),
    .dbgData(dbgData), .imemRdata(imemRdata),
    .running(running), .hlt(hlt),
    .imemWe(imemWe), .imemAddr(imemAddr), .imemWdata(imemWdata),
    .dbgAddr(dbgAddr), .start(start)
  );

  instrMem iIMEM (
    .clk(clk), .we(imemWe), .wrAddr(imemAddr), .wdata(imemWdata),
    .rdAddr(fetchAddr), .rdata(fetchInstr), .hostData(imemRdata)
  );

  regFile iRF (
    .clk(clk), .rst(rst),
    .rsAddr(rsAddr), .rtAddr(rtAddr),
    .we(wbWe), .wrAddr(wbAddr), .wdata(wbData),
    .dbgAddr(dbgAddr),
    .rsData(rsData), .rtData(rtData), .dbgData(dbgData)
  );

  // Three stage pipeline
  cpuCore iCORE (
    .clk(clk), .rst(rst), .start(start),
    .fetchInstr(fetchInstr), .rsData(rsData), .rtData(rtData),
    .fetchAddr(fetchAddr), .pc(pc), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .wbWe(wbWe), .wbAddr(wbAddr), .wbData(wbData),
    .running(running), .hlt(hlt)
  );

endmodule

`default_nettype wire

// File: verilog/cpuCore.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module cpuCore import cpuPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,       // One cycle pulse from the host
  input  instr_u              fetchInstr,
  input  word_t               rsData,
  input  word_t               rtData,
  output logic [`IMEM_AW-1:0] fetchAddr,
  output word_t               pc,
  output regIdx_t             rsAddr,
  output regIdx_t             rtAddr,
  output logic                wbWe,
  output regIdx_t             wbAddr,
  output word_t               wbData,
  output logic                running,
  output logic                hlt
);

  fetchStage_s ifReg;     // Fetch to execute
  wbStage_s    wbReg;     // Execute to write-back
  instr_u      exInstr;
  opcode_e     exOp;
  word_t       opA, opB;  // Operands after forwarding
  word_t       exResult;
  word_t       brTarget;
  logic        exValid, exWe, exHalt;
  logic        brTaken;
  logic        wbHalt;
  logic        advance;   // Fetch moves on this cycle

  ////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////
  assign fetchAddr = pc[`IMEM_AW-1:0];  // Upper pc bits wrap

  ////////////////////////////////////////////////////////////
  // Execute, decode and operand select
  ////////////////////////////////////////////////////////////
  assign exInstr = ifReg.instr;
  assign exOp    = exInstr.r.opcode;
  assign exValid = ifReg.valid;
  assign rsAddr  = (exOp == BZ) ? exInstr.i.rd : exInstr.r.rs;  // BZ tests rd
  assign rtAddr  = exInstr.r.rt;

  // Write-back result beats the stale register file copy
  assign opA = (wbWe && wbAddr == rsAddr) ? wbReg.result : rsData;
  assign opB = (wbWe && wbAddr == rtAddr) ? wbReg.result : rtData;

  always_comb begin
    exResult = '0;
    exWe     = 1'b0;
    case (exOp)
      ADD: begin exResult = opA + opB; exWe = 1'b1; end   // Wraps
      SUB: begin exResult = opA - opB; exWe = 1'b1; end
      AND: begin exResult = opA & opB; exWe = 1'b1; end
      XOR: begin exResult = opA ^ opB; exWe = 1'b1; end
      LLI: begin
        exResult = {{(`DATA_W-8){1'b0}}, exInstr.i.imm};  // Zero extended
        exWe     = 1'b1;
      end
      default: ;  // BZ, HLT and unused codes write nothing
    endcase
  end

  // Branch resolves here, always predicted not taken
  assign brTaken  = exValid && exOp == BZ && opA == '0;
  assign brTarget = ifReg.pc + 1'b1 + {{(`DATA_W-8){exInstr.i.imm[7]}}, exInstr.i.imm};

  assign exHalt  = exValid && exOp == HLT;
  assign wbHalt  = wbReg.valid && wbReg.halt;
  assign advance = running && !exHalt && !wbHalt;  // pc freezes behind HLT

  ////////////////////////////////////////////////////////////
  // Write-back port
  ////////////////////////////////////////////////////////////
  assign wbWe   = wbReg.valid && wbReg.we;
  assign wbAddr = wbReg.rd;
  assign wbData = wbReg.result;

  always_ff @(posedge clk) begin
    ifReg.pc     <= pc;
    ifReg.instr  <= fetchInstr;
    wbReg.rd     <= exInstr.r.rd;
    wbReg.we     <= exWe;
    wbReg.result <= exResult;
    wbReg.halt   <= exHalt;
    if (rst) begin
      pc          <= '0;
      running     <= 1'b0;
      hlt         <= 1'b0;
      ifReg.valid <= 1'b0;
      wbReg.valid <= 1'b0;
    end else if (start) begin  // Restart from address 0 with empty stages
      pc          <= '0;
      running     <= 1'b1;
      hlt         <= 1'b0;
      ifReg.valid <= 1'b0;
      wbReg.valid <= 1'b0;
    end else begin
      ifReg.valid <= advance && !brTaken;  // Taken branch kills the wrong path
      wbReg.valid <= exValid;
      if (brTaken)      pc <= brTarget;
      else if (advance) pc <= pc + 1'b1;
      if (wbHalt) begin  // HLT leaves write-back
        hlt     <= 1'b1;
        running <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/cpuPkg.sv
`include "cpu_defs.svh"

package cpuPkg;

  localparam int REG_AW = $clog2(`NUM_REGS);  // Register index bits

  typedef logic [`DATA_W-1:0] word_t;
  typedef logic [REG_AW-1:0]  regIdx_t;

  // Any code not listed runs as a no-op
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    XOR = 4'd3,
    LLI = 4'd4,
    BZ  = 4'd6,
    HLT = 4'd15
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // Instruction word, seen two ways
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    opcode_e opcode;
    regIdx_t rd;     // Destination
    regIdx_t rs;     // First source
    regIdx_t rt;     // Second source
  } rType_s;

  typedef struct packed {
    opcode_e    opcode;
    regIdx_t    rd;    // LLI destination, BZ test register
    logic [7:0] imm;   // LLI value or BZ offset
  } iType_s;

  typedef union packed {
    rType_s r;
    iType_s i;
  } instr_u;

  // APB bundles, host side naming
  typedef struct packed {
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`APB_AW-1:0] paddr;
    word_t              pwdata;
  } apbReq_s;

  typedef struct packed {
    logic  pready;
    word_t prdata;
    logic  pslverr;   // Only meaningful with pready
  } apbRsp_s;

  ////////////////////////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic   valid;
    word_t  pc;      // Address the word came from
    instr_u instr;
  } fetchStage_s;

  typedef struct packed {
    logic    valid;
    regIdx_t rd;
    logic    we;       // Writes rd on leaving write-back
    word_t   result;
    logic    halt;     // HLT has arrived
  } wbStage_s;

endpackage

// File: verilog/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath
`define DATA_W      16    // Machine word
`define NUM_REGS    16    // General purpose registers

// Instruction buffer
`define IMEM_DEPTH  64    // Words
`define IMEM_AW     6     // Word address bits

// APB side, byte addresses with 4-byte stride
`define APB_AW      12
`define IMEM_BASE   12'h000   // Program window
`define REG_BASE    12'h100   // Register file window, read only
`define CTRL_ADDR   12'h200   // Start on write, status on read

`endif

// File: verilog/instrMem.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module instrMem import cpuPkg::*; (
  input  logic                clk,
  input  logic                we,        // From the APB side
  input  logic [`IMEM_AW-1:0] wrAddr,    // Also the host read address
  input  word_t               wdata,
  input  logic [`IMEM_AW-1:0] rdAddr,    // Fetch address
  output instr_u              rdata,     // Same cycle as rdAddr
  output word_t               hostData   // Word at wrAddr
);

  instr_u mem [`IMEM_DEPTH];  // Program store, contents survive reset

  always_ff @(posedge clk) begin
    if (we) mem[wrAddr] <= wdata;
  end

  ////////////////////////////////////////////////////////////
  // Asynchronous read ports
  ////////////////////////////////////////////////////////////
  assign rdata    = mem[rdAddr];
  assign hostData = mem[wrAddr];  // Program check from the host

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module regFile import cpuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  regIdx_t rsAddr,
  input  regIdx_t rtAddr,
  input  logic    we,
  input  regIdx_t wrAddr,
  input  word_t   wdata,
  input  regIdx_t dbgAddr,
  output word_t   rsData,
  output word_t   rtData,
  output word_t   dbgData
);

  word_t regs [`NUM_REGS];  // r0 is an ordinary register

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) regs[i] <= '0;
    end else if (we) begin
      regs[wrAddr] <= wdata;
    end
  end

  // Execute operands, no internal bypass
  assign rsData = regs[rsAddr];
  assign rtData = regs[rtAddr];

  // Host port, one cycle late
  always_ff @(posedge clk) begin
    dbgData <= regs[dbgAddr];
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/apbLoader.sv
verilog/instrMem.sv
verilog/regFile.sv
verilog/cpuCore.sv
verilog/cpu.sv
tests/tbClock.sv
tests/cpu_asserts.sv
tests/cpuTb.sv
